/* src.f */
src/cpu_pkg.sv
src/internal_rom.sv
src/instr_cache.sv
src/fetch_unit.sv
src/instr_queue.sv
src/instr_decoder.sv
src/cpu_frontend.sv
dv/bus_mem_model.sv
dv/tb_cpu_frontend.sv

/* Bender.yml */
package:
  name: cpu_frontend

sources:
  - src/cpu_pkg.sv
  - src/internal_rom.sv
  - src/instr_cache.sv
  - src/fetch_unit.sv
  - src/instr_queue.sv
  - src/instr_decoder.sv
  - src/cpu_frontend.sv
  - target: test
    files:
      - dv/bus_mem_model.sv
      - dv/tb_cpu_frontend.sv

/* dv/tb_cpu_frontend.sv */
`default_nettype none

module tb_cpu_frontend;

   timeunit 1ns;
   timeprecision 100ps;

   localparam int NUM_ROWS = 30;

   logic               clk_i;
   logic               rst_n_i;
   logic [19:4]        bus_addr_o;
   logic               bus_valid_o;
   logic [127:0]       bus_data_i;
   logic               bus_valid_i;
   logic               dec_valid_o;
   logic [31:0]        dec_pc_o;
   cpu_pkg::op_class_e dec_class_o;
   logic [4:0]         dec_rd_o;
   logic [4:0]         dec_rs1_o;
   logic [4:0]         dec_rs2_o;
   logic [31:0]        dec_imm_o;

   logic [31:0] tbl_pc [NUM_ROWS];
   logic [31:0] tbl_instr [NUM_ROWS];
   logic        line_seen [logic [19:4]];
   int          decode_errors = 0;
   int          bus_errors = 0;
   int          bus_requests = 0;
   bit          run_over = 1'b0;

   cpu_frontend i_dut (
      .clk_i (clk_i), .rst_n_i (rst_n_i),
      .bus_addr_o (bus_addr_o), .bus_valid_o (bus_valid_o),
      .bus_data_i (bus_data_i), .bus_valid_i (bus_valid_i),
      .dec_valid_o (dec_valid_o), .dec_pc_o (dec_pc_o), .dec_class_o (dec_class_o),
      .dec_rd_o (dec_rd_o), .dec_rs1_o (dec_rs1_o), .dec_rs2_o (dec_rs2_o),
      .dec_imm_o (dec_imm_o)
   );

   bus_mem_model i_mem (
      .clk_i (clk_i), .req_i (bus_valid_o), .addr_i (bus_addr_o),
      .data_o (bus_data_i), .valid_o (bus_valid_i)
   );

   initial begin
      clk_i = 1'b0;
      forever #2 clk_i = ~clk_i;
   end

   // one pass through the loop body runs from 0x100 to 0x11c and then from 0x140 to 0x14c.
   task automatic fill_loop_rows(input int first);
      logic [31:0] words [12];
      words = '{32'h00100293, 32'h00528333, 32'h00628863, 32'hfe62ae23,
                32'h1234a0ff, 32'hff812383, 32'habcde437, 32'h0240006f,
                32'hfff48493, 32'h00548533, 32'hfe049ce3, 32'hfb5ff06f};
      for (int i = 0; i < 12; i++) begin
         tbl_pc[first + i] = (i < 8) ? 32'h100 + i * 4 : 32'h140 + (i - 8) * 4;
         tbl_instr[first + i] = words[i];
      end
   endtask

   task automatic build_table();
      logic [31:0] boot [6];
      boot = '{32'h00500093, 32'h12345137, 32'h002081b3,
               32'h0080a203, 32'h00312623, 32'h0ec000ef};
      for (int i = 0; i < 6; i++) begin
         tbl_pc[i] = i * 4;
         tbl_instr[i] = boot[i];
      end
      fill_loop_rows(6);
      fill_loop_rows(18);  // second pass hits lines that are already filled.
   endtask

   function automatic logic [2:0] expected_class(input logic [31:0] instr);
      case (instr[6:0])
         7'h33:   return 3'(cpu_pkg::CLS_ALU);
         7'h13:   return 3'(cpu_pkg::CLS_ALU_IMM);
         7'h03:   return 3'(cpu_pkg::CLS_LOAD);
         7'h23:   return 3'(cpu_pkg::CLS_STORE);
         7'h63:   return 3'(cpu_pkg::CLS_BRANCH);
         7'h6f:   return 3'(cpu_pkg::CLS_JAL);
         7'h37:   return 3'(cpu_pkg::CLS_LUI);
         default: return 3'(cpu_pkg::CLS_OTHER);
      endcase
   endfunction

   function automatic logic [31:0] expected_imm(input logic [31:0] instr);
      logic [31:0] sx;
      sx = {32{instr[31]}};
      case (instr[6:0])
         7'h13, 7'h03: return {sx[31:12], instr[31:20]};
         7'h23:        return {sx[31:12], instr[31:25], instr[11:7]};
         7'h63:        return {sx[31:13], instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
         7'h6f:        return {sx[31:21], instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};
         7'h37:        return {instr[31:12], 12'h000};
         default:      return 32'h0;
      endcase
   endfunction

   task automatic check_row(input int row);
      logic [31:0] instr;
      instr = tbl_instr[row];
      assert (dec_pc_o == tbl_pc[row]) else begin
         decode_errors++;
         $display("[FAIL] row %0d dec_pc_o got %h exp %h", row, dec_pc_o, tbl_pc[row]);
      end
      assert (3'(dec_class_o) == expected_class(instr)) else begin
         decode_errors++;
         $display("[FAIL] row %0d dec_class_o got %h exp %h", row, 3'(dec_class_o),
                  expected_class(instr));
      end
      assert (dec_rd_o == instr[11:7] && dec_rs1_o == instr[19:15] &&
              dec_rs2_o == instr[24:20]) else begin
         decode_errors++;
         $display("[FAIL] row %0d dec_rd_o/dec_rs1_o/dec_rs2_o got %h/%h/%h exp %h/%h/%h",
                  row, dec_rd_o, dec_rs1_o, dec_rs2_o, instr[11:7], instr[19:15],
                  instr[24:20]);
      end
      assert (dec_imm_o == expected_imm(instr)) else begin
         decode_errors++;
         $display("[FAIL] row %0d dec_imm_o got %h exp %h", row, dec_imm_o,
                  expected_imm(instr));
      end
   endtask

   task automatic end_run(input bit timed_out);
      if (run_over) return;
      run_over = 1'b1;
      $display("errors: %0d decode, %0d bus, %0d timeout (bus requests %0d)",
               decode_errors, bus_errors, timed_out, bus_requests);
      if (decode_errors == 0 && bus_errors == 0 && !timed_out) begin
         $display("RESULT: PASS");
      end else begin
         $display("RESULT: FAIL");
      end
      $finish;
   endtask

   // each line may be requested once, and the address holds during a request.
   initial begin
      logic        prev_valid;
      logic [19:4] held_addr;
      prev_valid = 1'b0;
      held_addr = '0;
      forever begin
         @(negedge clk_i);
         if (bus_valid_o && !prev_valid) begin
            bus_requests++;
            held_addr = bus_addr_o;
            assert (bus_requests != 1 || bus_addr_o == 16'h0010) else begin
               bus_errors++;
               $display("[FAIL] bus_addr_o got %h exp %h", bus_addr_o, 16'h0010);
            end
            assert (!line_seen.exists(bus_addr_o)) else begin
               bus_errors++;
               $display("line %h was requested a second time", bus_addr_o);
            end
            line_seen[bus_addr_o] = 1'b1;
         end else if (bus_valid_o) begin
            assert (bus_addr_o == held_addr) else begin
               bus_errors++;
               $display("[FAIL] bus_addr_o got %h exp %h", bus_addr_o, held_addr);
            end
         end
         prev_valid = bus_valid_o;
      end
   end

   initial begin
      repeat (200 * NUM_ROWS) @(posedge clk_i);
      $display("watchdog expired before all expected decodes were seen");
      end_run(1'b1);
   end

   initial begin
      logic [19:4] needed [3];
      needed = '{16'h0010, 16'h0011, 16'h0014};
      rst_n_i = 1'b0;
      build_table();
      repeat (4) @(posedge clk_i);
      #0.5;
      rst_n_i = 1'b1;
      for (int row = 0; row < NUM_ROWS; row++) begin
         do @(negedge clk_i); while (!dec_valid_o);
         check_row(row);
      end
      foreach (needed[i]) begin
         assert (line_seen.exists(needed[i])) else begin
            bus_errors++;
            $display("line %h was decoded from but never requested", needed[i]);
         end
      end
      end_run(1'b0);
   end

endmodule

`default_nettype wire

/* dv/bus_mem_model.sv */
`default_nettype none

module bus_mem_model (
   input  wire          clk_i,
   input  wire          req_i,
   input  wire  [19:4]  addr_i,
   output logic [127:0] data_o,
   output logic         valid_o
);

   timeunit 1ns;
   timeprecision 100ps;

   localparam logic [19:0] IMAGE_BASE = 20'h00100;

   logic [31:0] image [32];  // program for byte addresses 0x100 to 0x17f.

   // words outside the image carry their own byte address.
   function automatic logic [127:0] read_line(input logic [19:4] line_addr);
      logic [127:0] line;
      logic [19:0]  byte_addr;
      line = '0;
      for (int w = 0; w < 4; w++) begin
         byte_addr = {line_addr, w[1:0], 2'b00};
         if (byte_addr >= IMAGE_BASE && byte_addr < IMAGE_BASE + 20'h80) begin
            line[w*32 +: 32] = image[(byte_addr - IMAGE_BASE) >> 2];
         end else begin
            line[w*32 +: 32] = {12'ha5a, byte_addr};
         end
      end
      return line;
   endfunction

   initial begin
      int latency;
      for (int i = 0; i < 32; i++) image[i] = 32'h00000013;  // nop.
      image[0]  = 32'h00100293;  // addi x5, x0, 1.
      image[1]  = 32'h00528333;  // add  x6, x5, x5.
      image[2]  = 32'h00628863;  // beq  x5, x6, +16.
      image[3]  = 32'hfe62ae23;  // sw   x6, -4(x5).
      image[4]  = 32'h1234a0ff;  // unknown opcode.
      image[5]  = 32'hff812383;  // lw   x7, -8(x2).
      image[6]  = 32'habcde437;  // lui  x8, 0xabcde.
      image[7]  = 32'h0240006f;  // jal  x0, 0x140.
      image[16] = 32'hfff48493;  // addi x9, x9, -1.
      image[17] = 32'h00548533;  // add  x10, x9, x5.
      image[18] = 32'hfe049ce3;  // bne  x9, x0, -8.
      image[19] = 32'hfb5ff06f;  // jal  x0, 0x100.
      valid_o = 1'b0;
      data_o = '0;
      void'($urandom(32'he89b1b7a));
      forever begin
         @(posedge clk_i);
         #0.5;
         if (req_i) begin
            latency = $urandom_range(6, 1);  // cycles until the line comes back.
            if (latency > 1) begin
               repeat (latency - 1) @(posedge clk_i);
               #0.5;
            end
            data_o = read_line(addr_i);
            valid_o = 1'b1;
            @(posedge clk_i);
            #0.5;
            valid_o = 1'b0;
         end
      end
   end

endmodule

`default_nettype wire

/* src/cpu_frontend.sv */
`default_nettype none

module cpu_frontend (
   input  wire clk_i,
   input  wire rst_n_i,

   output logic [cpu_pkg::BUS_ADDRESS_WIDTH-1:cpu_pkg::BUS_DATA_WIDTH_SHIFT] bus_addr_o,
   output logic                                                            bus_valid_o,
   input  wire  [cpu_pkg::BUS_DATA_WIDTH-1:0]                              bus_data_i,
   input  wire                                                             bus_valid_i,

   output logic               dec_valid_o,
   output logic [31:0]        dec_pc_o,
   output cpu_pkg::op_class_e dec_class_o,
   output logic [4:0]         dec_rd_o,
   output logic [4:0]         dec_rs1_o,
   output logic [4:0]         dec_rs2_o,
   output logic [31:0]        dec_imm_o
);

   logic        iq_full;
   logic        iq_push;
   logic [31:0] iq_push_instr;
   logic [31:0] iq_push_pc;
   logic        iq_flush;
   logic        iq_empty;
   logic [31:0] iq_head_instr;
   logic [31:0] iq_head_pc;
   logic        iq_pop;
   logic        redirect;
   logic [31:0] redirect_pc;

   fetch_unit fetch (
      .clk_i           (clk_i),
      .rst_n_i         (rst_n_i),
      .bus_addr_o      (bus_addr_o),
      .bus_valid_o     (bus_valid_o),
      .bus_data_i      (bus_data_i),
      .bus_valid_i     (bus_valid_i),
      .iq_full_i       (iq_full),
      .iq_push_o       (iq_push),
      .iq_push_instr_o (iq_push_instr),
      .iq_push_pc_o    (iq_push_pc),
      .iq_flush_o      (iq_flush),
      .redirect_i      (redirect),
      .redirect_pc_i   (redirect_pc)
   );

   instr_queue iq (
      .clk_i        (clk_i),
      .rst_n_i      (rst_n_i),
      .push_i       (iq_push),
      .push_instr_i (iq_push_instr),
      .push_pc_i    (iq_push_pc),
      .pop_i        (iq_pop),
      .flush_i      (iq_flush),
      .full_o       (iq_full),
      .empty_o      (iq_empty),
      .head_instr_o (iq_head_instr),
      .head_pc_o    (iq_head_pc)
   );

   instr_decoder decoder (
      .clk_i         (clk_i),
      .rst_n_i       (rst_n_i),
      .empty_i       (iq_empty),
      .head_instr_i  (iq_head_instr),
      .head_pc_i     (iq_head_pc),
      .pop_o         (iq_pop),
      .redirect_o    (redirect),
      .redirect_pc_o (redirect_pc),
      .dec_valid_o   (dec_valid_o),
      .dec_pc_o      (dec_pc_o),
      .dec_class_o   (dec_class_o),
      .dec_rd_o      (dec_rd_o),
      .dec_rs1_o     (dec_rs1_o),
      .dec_rs2_o     (dec_rs2_o),
      .dec_imm_o     (dec_imm_o)
   );

endmodule

`default_nettype wire

/* src/instr_decoder.sv */
`default_nettype none

module instr_decoder (
   input  wire         clk_i,
   input  wire         rst_n_i,

   input  wire         empty_i,
   input  wire  [31:0] head_instr_i,
   input  wire  [31:0] head_pc_i,
   output logic        pop_o,

   output logic        redirect_o,
   output logic [31:0] redirect_pc_o,

   output logic               dec_valid_o,
   output logic [31:0]        dec_pc_o,
   output cpu_pkg::op_class_e dec_class_o,
   output logic [4:0]         dec_rd_o,
   output logic [4:0]         dec_rs1_o,
   output logic [4:0]         dec_rs2_o,
   output logic [31:0]        dec_imm_o
);

   logic [6:0]         opcode;
   cpu_pkg::op_class_e cls;
   logic [31:0]        imm_i;
   logic [31:0]        imm_s;
   logic [31:0]        imm_b;
   logic [31:0]        imm_j;
   logic [31:0]        imm_u;
   logic [31:0]        imm;

   assign opcode = head_instr_i[6:0];

   assign imm_i = {{20{head_instr_i[31]}}, head_instr_i[31:20]};
   assign imm_s = {{20{head_instr_i[31]}}, head_instr_i[31:25], head_instr_i[11:7]};
   assign imm_b = {{19{head_instr_i[31]}}, head_instr_i[31], head_instr_i[7],
                   head_instr_i[30:25], head_instr_i[11:8], 1'b0};
   assign imm_j = {{11{head_instr_i[31]}}, head_instr_i[31], head_instr_i[19:12],
                   head_instr_i[20], head_instr_i[30:21], 1'b0};
   assign imm_u = {head_instr_i[31:12], 12'b0};

   always_comb begin
      case (opcode)
         cpu_pkg::OPC_OP:     cls = cpu_pkg::CLS_ALU;
         cpu_pkg::OPC_OP_IMM: cls = cpu_pkg::CLS_ALU_IMM;
         cpu_pkg::OPC_LOAD:   cls = cpu_pkg::CLS_LOAD;
         cpu_pkg::OPC_STORE:  cls = cpu_pkg::CLS_STORE;
         cpu_pkg::OPC_BRANCH: cls = cpu_pkg::CLS_BRANCH;
         cpu_pkg::OPC_JAL:    cls = cpu_pkg::CLS_JAL;
         cpu_pkg::OPC_LUI:    cls = cpu_pkg::CLS_LUI;
         default:             cls = cpu_pkg::CLS_OTHER;
      endcase
   end

   always_comb begin
      case (cls)
         cpu_pkg::CLS_ALU_IMM,
         cpu_pkg::CLS_LOAD:   imm = imm_i;
         cpu_pkg::CLS_STORE:  imm = imm_s;
         cpu_pkg::CLS_BRANCH: imm = imm_b;
         cpu_pkg::CLS_JAL:    imm = imm_j;
         cpu_pkg::CLS_LUI:    imm = imm_u;
         default:             imm = '0;  // register ops carry no immediate.
      endcase
   end

   // nothing is taken while a redirect flushes the queue.
   assign pop_o = ~empty_i & ~redirect_o;

   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         dec_valid_o <= 1'b0;
         redirect_o <= 1'b0;
      end else begin
         dec_valid_o <= pop_o;
         redirect_o <= pop_o & (cls == cpu_pkg::CLS_JAL);
      end
   end

   always_ff @(posedge clk_i) begin
      if (pop_o) begin
         dec_pc_o <= head_pc_i;
         dec_class_o <= cls;
         dec_rd_o <= head_instr_i[11:7];
         dec_rs1_o <= head_instr_i[19:15];
         dec_rs2_o <= head_instr_i[24:20];
         dec_imm_o <= imm;
         redirect_pc_o <= head_pc_i + imm_j;
      end
   end

endmodule

`default_nettype wire

/* src/instr_queue.sv */
`default_nettype none

module instr_queue (
   input  wire         clk_i,
   input  wire         rst_n_i,

   input  wire         push_i,
   input  wire  [31:0] push_instr_i,
   input  wire  [31:0] push_pc_i,
   input  wire         pop_i,
   input  wire         flush_i,

   output logic        full_o,
   output logic        empty_o,
   output logic [31:0] head_instr_o,
   output logic [31:0] head_pc_o
);

   logic [31:0] instr_mem [cpu_pkg::IQ_DEPTH];
   logic [31:0] pc_mem [cpu_pkg::IQ_DEPTH];

   logic [cpu_pkg::IQ_PTR_WIDTH-1:0] wr_ptr_q;
   logic [cpu_pkg::IQ_PTR_WIDTH-1:0] rd_ptr_q;
   logic [cpu_pkg::IQ_PTR_WIDTH:0]   count_q;
   logic                             do_push;
   logic                             do_pop;

   assign full_o = count_q == (cpu_pkg::IQ_PTR_WIDTH + 1)'(cpu_pkg::IQ_DEPTH);
   assign empty_o = count_q == '0;
   assign do_push = push_i & ~full_o;
   assign do_pop = pop_i & ~empty_o;

   assign head_instr_o = instr_mem[rd_ptr_q];
   assign head_pc_o = pc_mem[rd_ptr_q];

   always_ff @(posedge clk_i) begin
      if (do_push) begin
         instr_mem[wr_ptr_q] <= push_instr_i;
         pc_mem[wr_ptr_q] <= push_pc_i;
      end
   end

   // the depth is a power of two, so the pointers wrap by themselves.
   always_ff @(posedge clk_i) begin
      if (!rst_n_i || flush_i) begin
         wr_ptr_q <= '0;
         rd_ptr_q <= '0;
         count_q <= '0;
      end else begin
         if (do_push) wr_ptr_q <= wr_ptr_q + 1'b1;
         if (do_pop) rd_ptr_q <= rd_ptr_q + 1'b1;
         case ({do_push, do_pop})
            2'b10:   count_q <= count_q + 1'b1;
            2'b01:   count_q <= count_q - 1'b1;
            default: count_q <= count_q;  // both or neither leave the count alone.
         endcase
      end
   end

endmodule

`default_nettype wire

/* src/fetch_unit.sv */
`default_nettype none

module fetch_unit (
   input  wire         clk_i,
   input  wire         rst_n_i,

   output logic [cpu_pkg::BUS_ADDRESS_WIDTH-1:cpu_pkg::BUS_DATA_WIDTH_SHIFT] bus_addr_o,
   output logic                                                            bus_valid_o,
   input  wire  [cpu_pkg::BUS_DATA_WIDTH-1:0]                              bus_data_i,
   input  wire                                                             bus_valid_i,

   input  wire         iq_full_i,
   output logic        iq_push_o,
   output logic [31:0] iq_push_instr_o,
   output logic [31:0] iq_push_pc_o,
   output logic        iq_flush_o,

   input  wire         redirect_i,
   input  wire  [31:0] redirect_pc_i
);

   logic [31:0] pc_q;
   logic        use_rom;
   logic        src_ready;
   logic [31:0] rom_data;
   logic [31:0] icache_data;
   logic        icache_ready_n;

   // the source is picked from the address and the rom always answers at once.
   assign use_rom = pc_q < cpu_pkg::ROM_LIMIT;
   assign src_ready = use_rom | icache_ready_n;

   assign iq_push_instr_o = use_rom ? rom_data : icache_data;
   assign iq_push_pc_o = pc_q;
   assign iq_push_o = src_ready & ~iq_full_i & ~redirect_i;
   assign iq_flush_o = redirect_i;  // words fetched past the jump are dropped.

   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         pc_q <= '0;
      end else if (redirect_i) begin
         pc_q <= redirect_pc_i;
      end else if (iq_push_o) begin
         pc_q <= pc_q + 32'd4;
      end
   end

   instr_cache icache (
      .clk_i       (clk_i),
      .rst_n_i     (rst_n_i),
      .addr_i      (pc_q[31:2]),
      .data_o      (icache_data),
      .ready_n_o   (icache_ready_n),
      .bus_addr_o  (bus_addr_o),
      .bus_valid_o (bus_valid_o),
      .bus_data_i  (bus_data_i),
      .bus_valid_i (bus_valid_i)
   );

   internal_rom rom (
      .addr_i (pc_q[cpu_pkg::ROM_ADDR_WIDTH+1:2]),
      .data_o (rom_data)
   );

endmodule

`default_nettype wire

/* src/instr_cache.sv */
`default_nettype none

module instr_cache (
   input  wire         clk_i,
   input  wire         rst_n_i,

   input  wire  [31:2] addr_i,
   output logic [31:0] data_o,
   output logic        ready_n_o,

   output logic [cpu_pkg::BUS_ADDRESS_WIDTH-1:cpu_pkg::BUS_DATA_WIDTH_SHIFT] bus_addr_o,
   output logic                                                            bus_valid_o,
   input  wire  [cpu_pkg::BUS_DATA_WIDTH-1:0]                              bus_data_i,
   input  wire                                                             bus_valid_i
);

   logic [cpu_pkg::ICACHE_LINES-1:0]     valid_q;
   logic [cpu_pkg::ICACHE_TAG_WIDTH-1:0] tag_q [cpu_pkg::ICACHE_LINES];
   logic [cpu_pkg::BUS_DATA_WIDTH-1:0]   line_q [cpu_pkg::ICACHE_LINES];

   logic [cpu_pkg::ICACHE_INDEX_WIDTH-1:0]   index;
   logic [cpu_pkg::ICACHE_TAG_WIDTH-1:0]     tag;
   logic [cpu_pkg::BUS_DATA_WIDTH_SHIFT-3:0] word_sel;
   logic                                     hit;
   logic                                     in_region;
   logic                                     need_fill;

   logic                                                            req_q;
   logic [cpu_pkg::BUS_ADDRESS_WIDTH-1:cpu_pkg::BUS_DATA_WIDTH_SHIFT] req_addr_q;
   logic [cpu_pkg::ICACHE_INDEX_WIDTH-1:0]                          fill_index;
   logic [cpu_pkg::ICACHE_TAG_WIDTH-1:0]                            fill_tag;

   // split the word address into tag, line index and word within the line.
   assign index = addr_i[cpu_pkg::BUS_DATA_WIDTH_SHIFT +: cpu_pkg::ICACHE_INDEX_WIDTH];
   assign tag = addr_i[cpu_pkg::BUS_DATA_WIDTH_SHIFT + cpu_pkg::ICACHE_INDEX_WIDTH +:
                       cpu_pkg::ICACHE_TAG_WIDTH];
   assign word_sel = addr_i[cpu_pkg::BUS_DATA_WIDTH_SHIFT-1:2];

   assign hit = valid_q[index] & (tag_q[index] == tag);
   assign in_region = {addr_i, 2'b00} >= cpu_pkg::ROM_LIMIT;  // the rom region never refills.
   assign need_fill = in_region & ~hit;

   assign data_o = line_q[index][word_sel * 32 +: 32];
   assign ready_n_o = hit;  // stays low until the refilled line is visible.

   // the outstanding request carries the line that gets written on return.
   assign fill_index = req_addr_q[cpu_pkg::BUS_DATA_WIDTH_SHIFT +: cpu_pkg::ICACHE_INDEX_WIDTH];
   assign fill_tag = req_addr_q[cpu_pkg::BUS_DATA_WIDTH_SHIFT + cpu_pkg::ICACHE_INDEX_WIDTH +:
                                cpu_pkg::ICACHE_TAG_WIDTH];

   assign bus_valid_o = req_q;
   assign bus_addr_o = req_addr_q;

   // miss/refill controller with one request in flight at a time.
   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         req_q <= 1'b0;
         valid_q <= '0;
      end else if (req_q) begin
         if (bus_valid_i) begin
            req_q <= 1'b0;
            valid_q[fill_index] <= 1'b1;
         end
      end else if (need_fill) begin
         req_q <= 1'b1;
      end
   end

   always_ff @(posedge clk_i) begin
      if (!req_q && need_fill) begin
         req_addr_q <= addr_i[cpu_pkg::BUS_ADDRESS_WIDTH-1:cpu_pkg::BUS_DATA_WIDTH_SHIFT];
      end
      if (req_q && bus_valid_i) begin
         tag_q[fill_index] <= fill_tag;
         line_q[fill_index] <= bus_data_i;
      end
   end

endmodule

`default_nettype wire

/* src/internal_rom.sv */
`default_nettype none

module internal_rom (
   input  wire [cpu_pkg::ROM_ADDR_WIDTH-1:0] addr_i,
   output logic [31:0]                       data_o
);

   // the boot program ends in a jump into the cached region.
   always_comb begin
      case (addr_i)
         4'd0:    data_o = 32'h00500093;  // addi x1, x0, 5.
         4'd1:    data_o = 32'h12345137;  // lui  x2, 0x12345.
         4'd2:    data_o = 32'h002081b3;  // add  x3, x1, x2.
         4'd3:    data_o = 32'h0080a203;  // lw   x4, 8(x1).
         4'd4:    data_o = 32'h00312623;  // sw   x3, 12(x2).
         4'd5:    data_o = 32'h0ec000ef;  // jal  x1, 0x100.
         default: data_o = 32'h00000013;  // nop.
      endcase
   end

endmodule

`default_nettype wire

/* src/cpu_pkg.sv */
`default_nettype none

package cpu_pkg;

   localparam int BUS_ADDRESS_WIDTH = 20;    // byte address width of the external bus.
   localparam int BUS_DATA_WIDTH_SHIFT = 4;  // log2 of the bus width in bytes.
   localparam int BUS_DATA_WIDTH = (2 ** BUS_DATA_WIDTH_SHIFT) * 8;

   localparam int ICACHE_LINES = 16;
   localparam int ICACHE_INDEX_WIDTH = $clog2(ICACHE_LINES);
   localparam int ICACHE_TAG_WIDTH =
      BUS_ADDRESS_WIDTH - BUS_DATA_WIDTH_SHIFT - ICACHE_INDEX_WIDTH;

   localparam int ROM_WORDS = 16;
   localparam int ROM_ADDR_WIDTH = $clog2(ROM_WORDS);
   localparam logic [31:0] ROM_LIMIT = ROM_WORDS * 4;  // pcs below this come from the rom.

   localparam int IQ_DEPTH = 4;
   localparam int IQ_PTR_WIDTH = $clog2(IQ_DEPTH);

   localparam logic [6:0] OPC_OP     = 7'b0110011;
   localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
   localparam logic [6:0] OPC_LOAD   = 7'b0000011;
   localparam logic [6:0] OPC_STORE  = 7'b0100011;
   localparam logic [6:0] OPC_BRANCH = 7'b1100011;
   localparam logic [6:0] OPC_JAL    = 7'b1101111;
   localparam logic [6:0] OPC_LUI    = 7'b0110111;

   typedef enum logic [2:0] {
      CLS_ALU,
      CLS_ALU_IMM,
      CLS_LOAD,
      CLS_STORE,
      CLS_BRANCH,
      CLS_JAL,
      CLS_LUI,
      CLS_OTHER
   } op_class_e;

endpackage

`default_nettype wire
